// ==== Makefile ====
SRCS := $(wildcard source/*.sv) test/decoder_tb.sv include/decoder_cfg.svh

.PHONY: all run clean

all: run

obj_dir/Vdecoder_tb: decoder.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps -f decoder.f --top-module decoder_tb

run: obj_dir/Vdecoder_tb
	./obj_dir/Vdecoder_tb | tee sim.log
	grep -qxF '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== decoder.f ====
+incdir+include
source/except_pkg.sv
source/inst_pkg.sv
source/id.sv
source/decode_queue.sv
source/decoder.sv
test/decoder_tb.sv

// ==== include/decoder_cfg.svh ====
`ifndef DECODER_CFG_SVH
`define DECODER_CFG_SVH

// power-of-two number of decoded record queue entries
`define DECODE_QUEUE_DEPTH 8

// slots per fetch bundle and per dispatch group
`define DECODE_WIDTH 2

`endif

// ==== source/decode_queue.sv ====
`timescale 1ns/1ps
`include "decoder_cfg.svh"

module decode_queue (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   flush,
    input  logic [`DECODE_WIDTH-1:0]               enq_valid,
    input  inst_pkg::decoded_t [`DECODE_WIDTH-1:0] enq_data,
    input  logic [`DECODE_WIDTH-1:0]               deq_en,
    output inst_pkg::decoded_t [`DECODE_WIDTH-1:0] head_data,
    output logic [`DECODE_WIDTH-1:0]               head_valid,
    output logic                                   has_room
);

    localparam int DEPTH = `DECODE_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    inst_pkg::decoded_t mem [DEPTH];

    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr_1;  // slot after wr_ptr, wraps
    logic [PTR_W-1:0]   rd_ptr_1;
    logic [CNT_W-1:0]   count;
    logic [1:0]         n_enq;
    logic [1:0]         n_deq;
    logic               pop_0;
    logic               pop_1;
    inst_pkg::decoded_t first_data;

    assign wr_ptr_1 = wr_ptr + 1'b1;
    assign rd_ptr_1 = rd_ptr + 1'b1;

    assign head_valid[0] = (count != '0);
    assign head_valid[1] = (count > CNT_W'(1));
    assign head_data[0]  = mem[rd_ptr];
    assign head_data[1]  = mem[rd_ptr_1];

    assign has_room = (count <= CNT_W'(DEPTH - 2));  // two free entries

    // bit 1 only counts together with bit 0
    assign pop_0 = deq_en[0] & head_valid[0];
    assign pop_1 = pop_0 & deq_en[1] & head_valid[1];
    assign n_deq = 2'(pop_0) + 2'(pop_1);

    // compact so a lone slot 1 lands at wr_ptr
    assign n_enq      = 2'(enq_valid[0]) + 2'(enq_valid[1]);
    assign first_data = enq_valid[0] ? enq_data[0] : enq_data[1];

    always_ff @(posedge clk) begin
        if (|enq_valid) begin
            mem[wr_ptr] <= first_data;
        end
        if (&enq_valid) begin
            mem[wr_ptr_1] <= enq_data[1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(n_enq);
            rd_ptr <= rd_ptr + PTR_W'(n_deq);
            count  <= count + CNT_W'(n_enq) - CNT_W'(n_deq);
        end
    end

endmodule

// ==== source/decoder.sv ====
`timescale 1ns/1ps
`include "decoder_cfg.svh"

module decoder (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    flush,
    input  inst_pkg::fetch_slot_t [`DECODE_WIDTH-1:0] fetch_bundle,
    input  logic [`DECODE_WIDTH-1:0]                invalid_en,
    output logic                                    get_data_req,
    output inst_pkg::decoded_t [`DECODE_WIDTH-1:0]  dispatch_inst,
    output logic [`DECODE_WIDTH-1:0]                dispatch_valid
);

    inst_pkg::decoded_t [`DECODE_WIDTH-1:0] id_dec;
    logic [`DECODE_WIDTH-1:0]               id_valid;
    logic                                   has_room;

    // slot 0 is the older instruction
    id u_id_0 (
        .slot      (fetch_bundle[0]),
        .dec       (id_dec[0]),
        .dec_valid (id_valid[0])
    );

    id u_id_1 (
        .slot      (fetch_bundle[1]),
        .dec       (id_dec[1]),
        .dec_valid (id_valid[1])
    );

    decode_queue u_queue (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .enq_valid  (id_valid & {`DECODE_WIDTH{has_room}}),  // bundle ignored when full
        .enq_data   (id_dec),
        .deq_en     (invalid_en),
        .head_data  (dispatch_inst),
        .head_valid (dispatch_valid),
        .has_room   (has_room)
    );

    assign get_data_req = has_room;  // front end holds its bundle while low

endmodule

// ==== source/except_pkg.sv ====
package except_pkg;

    // 7-bit exception code in the ESTAT ecode encoding
    typedef enum logic [6:0] {
        EXC_NONE = 7'h00,
        EXC_SYS  = 7'h0B,  // syscall
        EXC_BRK  = 7'h0C,  // break
        EXC_INE  = 7'h0D   // instruction not exist
    } exc_cause_t;

    // exception state carried along with one instruction
    // flags[1:0] from fetch and flags[2] from decode
    typedef struct packed {
        logic [2:0]       flags;
        exc_cause_t [2:0] cause;  // one code per flag
    } exc_rec_t;

endpackage

// ==== source/id.sv ====
`timescale 1ns/1ps

module id (
    input  inst_pkg::fetch_slot_t slot,
    output inst_pkg::decoded_t    dec,
    output logic                  dec_valid
);

    logic [31:0] inst;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [31:0] si12_ext;
    logic [31:0] ui12_ext;
    logic [31:0] si20_hi;
    logic [31:0] offs16_ext;
    logic [31:0] offs26_ext;
    logic        fetch_exc;
    logic        read_rj;   // rj onto port 1
    logic        read_rk;   // rk onto port 2
    logic        read_rd;   // rd onto port 2 (stores, branches, csr)
    logic        write_rd;
    except_pkg::exc_cause_t dec_cause;

    assign inst = slot.inst;
    assign rd   = inst[4:0];
    assign rj   = inst[9:5];
    assign rk   = inst[14:10];

    assign si12_ext   = {{20{inst[21]}}, inst[21:10]};
    assign ui12_ext   = {20'd0, inst[21:10]};
    assign si20_hi    = {inst[24:5], 12'd0};
    assign offs16_ext = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign offs26_ext = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    assign fetch_exc = |slot.exc_flags;
    assign dec_valid = slot.valid;

    always_comb begin
        dec           = '0;
        dec.pc        = slot.pc;
        dec.inst      = inst;
        dec.aluop     = inst_pkg::NOP;
        dec.alusel    = inst_pkg::SEL_NOP;
        dec.pre_taken = slot.pre_taken;
        dec.pre_addr  = slot.pre_addr;
        read_rj       = 1'b0;
        read_rk       = 1'b0;
        read_rd       = 1'b0;
        write_rd      = 1'b0;
        dec_cause     = except_pkg::EXC_NONE;

        casez (inst)
            // 3R group, opcode in [31:15]
            32'b0000_0000_0001_0000_0???_????_????_????: begin
                dec.aluop  = inst_pkg::ADD;
                dec.alusel = inst_pkg::SEL_ARITH;
                {read_rj, read_rk, write_rd} = 3'b111;
            end
            32'b0000_0000_0001_0001_0???_????_????_????: begin
                dec.aluop  = inst_pkg::SUB;
                dec.alusel = inst_pkg::SEL_ARITH;
                {read_rj, read_rk, write_rd} = 3'b111;
            end
            32'b0000_0000_0001_0010_0???_????_????_????: begin
                dec.aluop  = inst_pkg::SLT;
                dec.alusel = inst_pkg::SEL_ARITH;
                {read_rj, read_rk, write_rd} = 3'b111;
            end
            32'b0000_0000_0001_0010_1???_????_????_????: begin
                dec.aluop  = inst_pkg::SLTU;
                dec.alusel = inst_pkg::SEL_ARITH;
                {read_rj, read_rk, write_rd} = 3'b111;
            end
            32'b0000_0000_0001_0100_1???_????_????_????: begin
                dec.aluop  = inst_pkg::AND;
                dec.alusel = inst_pkg::SEL_LOGIC;
                {read_rj, read_rk, write_rd} = 3'b111;
            end
            32'b0000_0000_0001_0101_0???_????_????_????: begin
                dec.aluop  = inst_pkg::OR;
                dec.alusel = inst_pkg::SEL_LOGIC;
                {read_rj, read_rk, write_rd} = 3'b111;
            end
            32'b0000_0000_0001_0101_1???_????_????_????: begin
                dec.aluop  = inst_pkg::XOR;
                dec.alusel = inst_pkg::SEL_LOGIC;
                {read_rj, read_rk, write_rd} = 3'b111;
            end
            // 2RI12 group
            32'b0000_0010_10??_????_????_????_????_????: begin
                dec.aluop  = inst_pkg::ADD;
                dec.alusel = inst_pkg::SEL_ARITH;
                dec.imm    = si12_ext;
                {read_rj, write_rd} = 2'b11;
            end
            32'b0000_0011_01??_????_????_????_????_????: begin
                dec.aluop  = inst_pkg::AND;
                dec.alusel = inst_pkg::SEL_LOGIC;
                dec.imm    = ui12_ext;        // andi zero-extends
                {read_rj, write_rd} = 2'b11;
            end
            32'b0000_0011_10??_????_????_????_????_????: begin
                dec.aluop  = inst_pkg::OR;
                dec.alusel = inst_pkg::SEL_LOGIC;
                dec.imm    = ui12_ext;
                {read_rj, write_rd} = 2'b11;
            end
            32'b0001_010?_????_????_????_????_????_????: begin
                dec.aluop  = inst_pkg::LUI;
                dec.alusel = inst_pkg::SEL_LOGIC;
                dec.imm    = si20_hi;
                write_rd   = 1'b1;
            end
            32'b0010_1000_10??_????_????_????_????_????: begin
                dec.aluop  = inst_pkg::LDW;
                dec.alusel = inst_pkg::SEL_MEM;
                dec.imm    = si12_ext;
                {read_rj, write_rd} = 2'b11;
            end
            32'b0010_1001_10??_????_????_????_????_????: begin
                dec.aluop  = inst_pkg::STW;
                dec.alusel = inst_pkg::SEL_MEM;
                dec.imm    = si12_ext;
                {read_rj, read_rd} = 2'b11;  // rd is store data
            end
            // branches
            32'b0100_11??_????_????_????_????_????_????: begin
                dec.aluop  = inst_pkg::JIRL;
                dec.alusel = inst_pkg::SEL_JUMP;
                dec.imm    = offs16_ext;
                {read_rj, write_rd} = 2'b11;
            end
            32'b0101_00??_????_????_????_????_????_????: begin
                dec.aluop  = inst_pkg::B;
                dec.alusel = inst_pkg::SEL_JUMP;
                dec.imm    = offs26_ext;
            end
            32'b0101_01??_????_????_????_????_????_????: begin
                dec.aluop          = inst_pkg::BL;
                dec.alusel         = inst_pkg::SEL_JUMP;
                dec.imm            = offs26_ext;
                dec.reg_write_en   = 1'b1;
                dec.reg_write_addr = 5'd1;  // link register ra
            end
            32'b0101_10??_????_????_????_????_????_????: begin
                dec.aluop  = inst_pkg::BEQ;
                dec.alusel = inst_pkg::SEL_JUMP;
                dec.imm    = offs16_ext;
                {read_rj, read_rd} = 2'b11;
            end
            32'b0101_11??_????_????_????_????_????_????: begin
                dec.aluop  = inst_pkg::BNE;
                dec.alusel = inst_pkg::SEL_JUMP;
                dec.imm    = offs16_ext;
                {read_rj, read_rd} = 2'b11;
            end
            // csr ops share one opcode and rj picks the flavour
            32'b0000_0100_????_????_????_????_????_????: begin
                dec.alusel       = inst_pkg::SEL_CSR;
                dec.is_privilege = 1'b1;
                dec.csr_read_en  = 1'b1;
                dec.csr_addr     = inst[23:10];
                write_rd         = 1'b1;
                if (rj == 5'd0) begin
                    dec.aluop = inst_pkg::CSRRD;
                end else if (rj == 5'd1) begin
                    dec.aluop        = inst_pkg::CSRWR;
                    dec.csr_write_en = 1'b1;
                    read_rd          = 1'b1;
                end else begin
                    dec.aluop        = inst_pkg::CSRXCHG;
                    dec.csr_write_en = 1'b1;
                    {read_rj, read_rd} = 2'b11;  // rj holds the mask
                end
            end
            32'b0000_0000_0000_0000_0110_0000_000?_????: begin
                dec.aluop  = inst_pkg::RDCNTVL;
                dec.alusel = inst_pkg::SEL_CSR;
                dec.is_cnt = 1'b1;
                write_rd   = 1'b1;
            end
            32'b0000_0110_0100_1001_1???_????_????_????: begin
                dec.aluop        = inst_pkg::INVTLB;
                dec.is_privilege = 1'b1;
                dec.invtlb_op    = 1'b1;
                {read_rj, read_rk} = 2'b11;
            end
            32'b0000_0110_0100_1000_0011_1000_0000_0000: begin
                dec.aluop        = inst_pkg::ERTN;
                dec.is_privilege = 1'b1;
            end
            32'b0000_0000_0010_1011_0???_????_????_????: begin
                dec.aluop = inst_pkg::SYSCALL;
                dec_cause = except_pkg::EXC_SYS;
            end
            32'b0000_0000_0010_1010_0???_????_????_????: begin
                dec.aluop = inst_pkg::BREAK;
                dec_cause = except_pkg::EXC_BRK;
            end
            default: dec_cause = except_pkg::EXC_INE;  // outside the subset
        endcase

        if (read_rj) begin
            dec.reg1_read_en   = 1'b1;
            dec.reg1_read_addr = rj;
        end
        if (read_rk || read_rd) begin
            dec.reg2_read_en   = 1'b1;
            dec.reg2_read_addr = read_rk ? rk : rd;
        end
        if (write_rd) begin
            dec.reg_write_en   = 1'b1;
            dec.reg_write_addr = rd;
        end

        dec.exc.flags[1:0] = slot.exc_flags;
        dec.exc.cause[1:0] = slot.exc_cause;
        // an earlier fetch fault masks the decode one
        if (!fetch_exc && dec_cause != except_pkg::EXC_NONE) begin
            dec.exc.flags[2] = 1'b1;
            dec.exc.cause[2] = dec_cause;
        end
    end

endmodule

// ==== source/inst_pkg.sv ====
package inst_pkg;

    typedef enum logic [7:0] {
        NOP     = 8'd0,
        ADD     = 8'd1,
        SUB     = 8'd2,
        AND     = 8'd3,
        OR      = 8'd4,
        XOR     = 8'd5,
        SLT     = 8'd6,
        SLTU    = 8'd7,
        LUI     = 8'd8,
        LDW     = 8'd9,
        STW     = 8'd10,
        BEQ     = 8'd11,
        BNE     = 8'd12,
        B       = 8'd13,
        BL      = 8'd14,
        JIRL    = 8'd15,
        CSRRD   = 8'd16,
        CSRWR   = 8'd17,
        CSRXCHG = 8'd18,
        RDCNTVL = 8'd19,
        INVTLB  = 8'd20,
        ERTN    = 8'd21,
        SYSCALL = 8'd22,
        BREAK   = 8'd23
    } aluop_t;

    typedef enum logic [2:0] {
        SEL_NOP   = 3'd0,
        SEL_ARITH = 3'd1,
        SEL_LOGIC = 3'd2,
        SEL_MEM   = 3'd3,
        SEL_JUMP  = 3'd4,
        SEL_CSR   = 3'd5
    } alusel_t;

    // one slot of the front-end bundle
    typedef struct packed {
        logic                         valid;
        logic [31:0]                  pc;
        logic [31:0]                  inst;
        logic                         pre_taken;  // predicted taken
        logic [31:0]                  pre_addr;   // predicted target
        logic [1:0]                   exc_flags;
        except_pkg::exc_cause_t [1:0] exc_cause;
    } fetch_slot_t;

    typedef struct packed {
        logic [31:0]          pc;
        logic [31:0]          inst;
        aluop_t               aluop;
        alusel_t              alusel;
        logic [31:0]          imm;
        logic                 reg1_read_en;
        logic [4:0]           reg1_read_addr;
        logic                 reg2_read_en;
        logic [4:0]           reg2_read_addr;
        logic                 reg_write_en;
        logic [4:0]           reg_write_addr;
        logic                 pre_taken;
        logic [31:0]          pre_addr;
        logic                 is_privilege;
        logic                 csr_read_en;
        logic                 csr_write_en;
        logic [13:0]          csr_addr;
        logic                 is_cnt;      // rdcntvl.w
        logic                 invtlb_op;
        except_pkg::exc_rec_t exc;
    } decoded_t;

endpackage

// ==== test/decoder_tb.sv ====
`timescale 1ns/1ps
`include "decoder_cfg.svh"

module decoder_tb;

    localparam int WAIT_LIMIT = 50;  // cycles per wait

    typedef enum int {
        I_ADD, I_SUB, I_AND, I_OR, I_XOR, I_SLT, I_SLTU, I_ADDI, I_ANDI, I_ORI, I_LU12I,
        I_LDW, I_STW, I_BEQ, I_BNE, I_B, I_BL, I_JIRL, I_CSRRD, I_CSRWR, I_CSRXCHG,
        I_RDCNTVL, I_INVTLB, I_ERTN, I_SYSCALL, I_BREAK, I_UNKNOWN
    } kind_t;

    logic clk = 1'b0;
    logic rst;
    logic flush;
    inst_pkg::fetch_slot_t [`DECODE_WIDTH-1:0] fetch_bundle;
    logic [`DECODE_WIDTH-1:0]                  invalid_en;
    logic                                      get_data_req;
    inst_pkg::decoded_t [`DECODE_WIDTH-1:0]    dispatch_inst;
    logic [`DECODE_WIDTH-1:0]                  dispatch_valid;

    logic [31:0] rng = 32'h14e1_96c2;
    logic [31:0] next_pc = 32'h1c00_0000;
    int tests = 0;
    int failed_tests = 0;
    int checks = 0;
    int errors = 0;

    decoder dut (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .fetch_bundle   (fetch_bundle),
        .invalid_en     (invalid_en),
        .get_data_req   (get_data_req),
        .dispatch_inst  (dispatch_inst),
        .dispatch_valid (dispatch_valid)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // LoongArch-32 encodings of the supported subset
    function automatic logic [31:0] encode(input kind_t k, input logic [4:0] rd, rj, rk,
                                           input logic [31:0] imm);
        logic [31:0] r3;
        logic [31:0] ri12;
        logic [31:0] w;
        r3   = {17'd0, rk, rj, rd};
        ri12 = {10'd0, imm[11:0], rj, rd};
        case (k)
            I_ADD:     w = 32'h0010_0000 | r3;
            I_SUB:     w = 32'h0011_0000 | r3;
            I_SLT:     w = 32'h0012_0000 | r3;
            I_SLTU:    w = 32'h0012_8000 | r3;
            I_AND:     w = 32'h0014_8000 | r3;
            I_OR:      w = 32'h0015_0000 | r3;
            I_XOR:     w = 32'h0015_8000 | r3;
            I_ADDI:    w = 32'h0280_0000 | ri12;
            I_ANDI:    w = 32'h0340_0000 | ri12;
            I_ORI:     w = 32'h0380_0000 | ri12;
            I_LU12I:   w = 32'h1400_0000 | {7'd0, imm[19:0], rd};
            I_LDW:     w = 32'h2880_0000 | ri12;
            I_STW:     w = 32'h2980_0000 | ri12;
            I_JIRL:    w = 32'h4c00_0000 | {6'd0, imm[15:0], rj, rd};
            I_B:       w = 32'h5000_0000 | {6'd0, imm[15:0], imm[25:16]};
            I_BL:      w = 32'h5400_0000 | {6'd0, imm[15:0], imm[25:16]};
            I_BEQ:     w = 32'h5800_0000 | {6'd0, imm[15:0], rj, rd};
            I_BNE:     w = 32'h5c00_0000 | {6'd0, imm[15:0], rj, rd};
            I_CSRRD:   w = 32'h0400_0000 | {8'd0, imm[13:0], 5'd0, rd};
            I_CSRWR:   w = 32'h0400_0000 | {8'd0, imm[13:0], 5'd1, rd};
            I_CSRXCHG: w = 32'h0400_0000 | {8'd0, imm[13:0], rj, rd};
            I_RDCNTVL: w = 32'h0000_6000 | {27'd0, rd};
            I_INVTLB:  w = 32'h0649_8000 | r3;  // rd field is the op
            I_ERTN:    w = 32'h0648_3800;
            I_SYSCALL: w = 32'h002b_0000 | {17'd0, imm[14:0]};
            I_BREAK:   w = 32'h002a_0000 | {17'd0, imm[14:0]};
            default:   w = 32'hffff_ffff;  // no such opcode
        endcase
        return w;
    endfunction

    function automatic inst_pkg::decoded_t expect_decoded(input kind_t k,
            input inst_pkg::fetch_slot_t s, input logic [4:0] rd, rj, rk,
            input logic [31:0] imm);
        inst_pkg::decoded_t e;
        e           = '0;
        e.pc        = s.pc;
        e.inst      = s.inst;
        e.pre_taken = s.pre_taken;
        e.pre_addr  = s.pre_addr;
        case (k)
            I_ADD, I_ADDI:    e.aluop = inst_pkg::ADD;
            I_SUB:            e.aluop = inst_pkg::SUB;
            I_AND, I_ANDI:    e.aluop = inst_pkg::AND;
            I_OR, I_ORI:      e.aluop = inst_pkg::OR;
            I_XOR:            e.aluop = inst_pkg::XOR;
            I_SLT:            e.aluop = inst_pkg::SLT;
            I_SLTU:           e.aluop = inst_pkg::SLTU;
            I_LU12I:          e.aluop = inst_pkg::LUI;
            I_LDW:            e.aluop = inst_pkg::LDW;
            I_STW:            e.aluop = inst_pkg::STW;
            I_BEQ:            e.aluop = inst_pkg::BEQ;
            I_BNE:            e.aluop = inst_pkg::BNE;
            I_B:              e.aluop = inst_pkg::B;
            I_BL:             e.aluop = inst_pkg::BL;
            I_JIRL:           e.aluop = inst_pkg::JIRL;
            I_CSRRD:          e.aluop = inst_pkg::CSRRD;
            I_CSRWR:          e.aluop = inst_pkg::CSRWR;
            I_CSRXCHG:        e.aluop = inst_pkg::CSRXCHG;
            I_RDCNTVL:        e.aluop = inst_pkg::RDCNTVL;
            I_INVTLB:         e.aluop = inst_pkg::INVTLB;
            I_ERTN:           e.aluop = inst_pkg::ERTN;
            I_SYSCALL:        e.aluop = inst_pkg::SYSCALL;
            I_BREAK:          e.aluop = inst_pkg::BREAK;
            default:          e.aluop = inst_pkg::NOP;
        endcase
        case (k)
            I_ADD, I_SUB, I_SLT, I_SLTU, I_ADDI: e.alusel = inst_pkg::SEL_ARITH;
            I_AND, I_OR, I_XOR, I_ANDI, I_ORI, I_LU12I: e.alusel = inst_pkg::SEL_LOGIC;
            I_LDW, I_STW: e.alusel = inst_pkg::SEL_MEM;
            I_BEQ, I_BNE, I_B, I_BL, I_JIRL: e.alusel = inst_pkg::SEL_JUMP;
            I_CSRRD, I_CSRWR, I_CSRXCHG, I_RDCNTVL: e.alusel = inst_pkg::SEL_CSR;
            default: e.alusel = inst_pkg::SEL_NOP;
        endcase
        case (k)
            I_ADDI, I_LDW, I_STW: e.imm = {{20{imm[11]}}, imm[11:0]};
            I_ANDI, I_ORI:        e.imm = {20'd0, imm[11:0]};
            I_LU12I:              e.imm = {imm[19:0], 12'd0};
            I_BEQ, I_BNE, I_JIRL: e.imm = {{14{imm[15]}}, imm[15:0], 2'b00};
            I_B, I_BL:            e.imm = {{4{imm[25]}}, imm[25:0], 2'b00};
            default:              e.imm = 32'd0;
        endcase
        if (k inside {I_ADD, I_SUB, I_AND, I_OR, I_XOR, I_SLT, I_SLTU, I_ADDI, I_ANDI,
                      I_ORI, I_LDW, I_STW, I_BEQ, I_BNE, I_JIRL, I_CSRXCHG, I_INVTLB}) begin
            e.reg1_read_en   = 1'b1;
            e.reg1_read_addr = rj;
        end
        if (k inside {I_ADD, I_SUB, I_AND, I_OR, I_XOR, I_SLT, I_SLTU, I_INVTLB}) begin
            e.reg2_read_en   = 1'b1;
            e.reg2_read_addr = rk;
        end
        if (k inside {I_STW, I_BEQ, I_BNE, I_CSRWR, I_CSRXCHG}) begin
            e.reg2_read_en   = 1'b1;
            e.reg2_read_addr = rd;  // store data, compare or csr value
        end
        if (k inside {I_ADD, I_SUB, I_AND, I_OR, I_XOR, I_SLT, I_SLTU, I_ADDI, I_ANDI,
                      I_ORI, I_LU12I, I_LDW, I_JIRL, I_CSRRD, I_CSRWR, I_CSRXCHG,
                      I_RDCNTVL}) begin
            e.reg_write_en   = 1'b1;
            e.reg_write_addr = rd;
        end
        if (k == I_BL) begin
            e.reg_write_en   = 1'b1;
            e.reg_write_addr = 5'd1;
        end
        if (k inside {I_CSRRD, I_CSRWR, I_CSRXCHG}) begin
            e.csr_read_en  = 1'b1;
            e.csr_write_en = (k != I_CSRRD);
            e.csr_addr     = imm[13:0];
        end
        e.is_privilege = k inside {I_CSRRD, I_CSRWR, I_CSRXCHG, I_ERTN, I_INVTLB};
        e.is_cnt       = (k == I_RDCNTVL);
        e.invtlb_op    = (k == I_INVTLB);
        e.exc.flags[1:0] = s.exc_flags;
        e.exc.cause[1:0] = s.exc_cause;
        if (s.exc_flags == 2'b00 && k inside {I_SYSCALL, I_BREAK, I_UNKNOWN}) begin
            e.exc.flags[2] = 1'b1;
            e.exc.cause[2] = (k == I_SYSCALL) ? except_pkg::EXC_SYS :
                             (k == I_BREAK) ? except_pkg::EXC_BRK : except_pkg::EXC_INE;
        end
        return e;
    endfunction

    task automatic abort(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic check_exc(input string name, input except_pkg::exc_rec_t exp,
                             input except_pkg::exc_rec_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s exc expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_decoded(input string name, input inst_pkg::decoded_t exp,
                                 input inst_pkg::decoded_t act);
        inst_pkg::decoded_t exp_body;
        inst_pkg::decoded_t act_body;
        exp_body     = exp;
        act_body     = act;
        exp_body.exc = '0;
        act_body.exc = '0;
        checks++;
        if (exp_body !== act_body) begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, exp_body, act_body);
        end
        check_exc(name, exp.exc, act.exc);
    endtask

    task automatic check_bits(input string name, input logic [1:0] exp, input logic [1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic report_test(input string name, input int start);
        tests++;
        if (errors == start) begin
            $display("test %-10s ok", name);
        end else begin
            failed_tests++;
            $display("test %-10s failed with %0d errors", name, errors - start);
        end
    endtask

    task automatic wait_valid(input logic [1:0] want, input string name);
        int n;
        n = 0;
        while ((dispatch_valid & want) != want) begin
            if (n >= WAIT_LIMIT) begin
                abort({"timeout waiting for dispatch_valid in test ", name});
            end
            @(negedge clk);
            n++;
        end
    endtask

    // random operands, fresh pc, optional fetch fault on the slot
    task automatic make_slot(input kind_t k, input logic [1:0] fflags,
                             input except_pkg::exc_cause_t fcause,
                             output inst_pkg::fetch_slot_t s, output inst_pkg::decoded_t e);
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [31:0] imm;
        rng = xorshift32(rng);
        rd  = rng[4:0];
        rj  = rng[9:5];
        rk  = rng[14:10];
        if (k == I_CSRXCHG) begin
            rj = rj | 5'd2;  // rj of 0 or 1 means csrrd or csrwr
        end
        rng = xorshift32(rng);
        imm = rng;
        rng = xorshift32(rng);
        s              = '0;
        s.valid        = 1'b1;
        s.pc           = next_pc;
        s.inst         = encode(k, rd, rj, rk, imm);
        s.pre_taken    = rng[0];
        s.pre_addr     = rng ^ 32'h1c00_0000;
        s.exc_flags    = fflags;
        s.exc_cause[0] = fflags[0] ? fcause : except_pkg::EXC_NONE;
        s.exc_cause[1] = fflags[1] ? fcause : except_pkg::EXC_NONE;
        next_pc        = next_pc + 32'd4;
        e = expect_decoded(k, s, rd, rj, rk, imm);
    endtask

    task automatic send_bundle(input inst_pkg::fetch_slot_t s0, input inst_pkg::fetch_slot_t s1,
                               input string name);
        int n;
        n = 0;
        while (!get_data_req) begin
            if (n >= WAIT_LIMIT) begin
                abort({"timeout waiting for get_data_req in test ", name});
            end
            @(negedge clk);
            n++;
        end
        fetch_bundle[0] = s0;
        fetch_bundle[1] = s1;
        @(negedge clk);
        fetch_bundle = '0;
    endtask

    task automatic pop_entries(input logic [1:0] mask);
        invalid_en = mask;
        @(negedge clk);
        invalid_en = 2'b00;
    endtask

    task automatic decode_pair(input string name, input kind_t k0, input kind_t k1,
            input logic [1:0] fflags = 2'b00,
            input except_pkg::exc_cause_t fcause = except_pkg::EXC_NONE);
        inst_pkg::fetch_slot_t s0;
        inst_pkg::fetch_slot_t s1;
        inst_pkg::decoded_t    e0;
        inst_pkg::decoded_t    e1;
        make_slot(k0, fflags, fcause, s0, e0);
        make_slot(k1, 2'b00, except_pkg::EXC_NONE, s1, e1);
        send_bundle(s0, s1, name);
        wait_valid(2'b11, name);
        check_decoded(name, e0, dispatch_inst[0]);
        check_decoded(name, e1, dispatch_inst[1]);
        pop_entries(2'b11);
    endtask

    task automatic test_reset();
        int start;
        start = errors;
        check_bits("reset", 2'b00, dispatch_valid);
        check_bits("reset", 2'b01, {1'b0, get_data_req});
        report_test("reset", start);
    endtask

    task automatic test_alu();
        int start;
        start = errors;
        decode_pair("alu", I_ADD, I_SUB);
        decode_pair("alu", I_AND, I_OR);
        decode_pair("alu", I_XOR, I_SLT);
        decode_pair("alu", I_SLTU, I_ADDI);
        decode_pair("alu", I_ANDI, I_ORI);
        decode_pair("alu", I_LU12I, I_ADDI);
        report_test("alu", start);
    endtask

    task automatic test_mem_branch();
        int start;
        start = errors;
        decode_pair("mem_branch", I_LDW, I_STW);
        decode_pair("mem_branch", I_BEQ, I_BNE);
        decode_pair("mem_branch", I_B, I_BL);
        decode_pair("mem_branch", I_JIRL, I_LDW);
        report_test("mem_branch", start);
    endtask

    task automatic test_csr();
        int start;
        start = errors;
        decode_pair("csr", I_CSRRD, I_CSRWR);
        decode_pair("csr", I_CSRXCHG, I_ERTN);
        decode_pair("csr", I_RDCNTVL, I_INVTLB);
        report_test("csr", start);
    endtask

    task automatic test_exceptions();
        int start;
        start = errors;
        decode_pair("exceptions", I_ADD, I_SYSCALL, 2'b01, except_pkg::EXC_INE);
        decode_pair("exceptions", I_BREAK, I_UNKNOWN);
        decode_pair("exceptions", I_SYSCALL, I_UNKNOWN, 2'b10, except_pkg::EXC_BRK);
        report_test("exceptions", start);
    endtask

    task automatic test_queue();
        inst_pkg::fetch_slot_t s0;
        inst_pkg::fetch_slot_t s1;
        inst_pkg::decoded_t    e0;
        inst_pkg::decoded_t    e1;
        inst_pkg::decoded_t    exp_q[$];
        int start;
        start = errors;
        repeat (3) begin
            make_slot(I_ADDI, 2'b00, except_pkg::EXC_NONE, s0, e0);
            make_slot(I_LDW, 2'b00, except_pkg::EXC_NONE, s1, e1);
            send_bundle(s0, s1, "queue");
            exp_q.push_back(e0);
            exp_q.push_back(e1);
        end
        check_bits("queue", 2'b01, {1'b0, get_data_req});  // six stored, two free
        make_slot(I_XOR, 2'b00, except_pkg::EXC_NONE, s0, e0);
        s0.valid = 1'b0;
        make_slot(I_BNE, 2'b00, except_pkg::EXC_NONE, s1, e1);
        send_bundle(s0, s1, "queue");
        exp_q.push_back(e1);
        check_bits("queue", 2'b00, {1'b0, get_data_req});
        // offered while the request is low, must not be stored
        make_slot(I_OR, 2'b00, except_pkg::EXC_NONE, s0, e0);
        make_slot(I_AND, 2'b00, except_pkg::EXC_NONE, s1, e1);
        fetch_bundle[0] = s0;
        fetch_bundle[1] = s1;
        @(negedge clk);
        fetch_bundle = '0;
        wait_valid(2'b01, "queue");
        check_decoded("queue", exp_q[0], dispatch_inst[0]);
        pop_entries(2'b01);
        void'(exp_q.pop_front());
        pop_entries(2'b10);  // bit 1 alone pops nothing
        while (exp_q.size() >= 2) begin
            wait_valid(2'b11, "queue");
            check_decoded("queue", exp_q[0], dispatch_inst[0]);
            check_decoded("queue", exp_q[1], dispatch_inst[1]);
            pop_entries(2'b11);
            void'(exp_q.pop_front());
            void'(exp_q.pop_front());
        end
        check_bits("queue", 2'b00, dispatch_valid);
        report_test("queue", start);
    endtask

    task automatic test_flush();
        inst_pkg::fetch_slot_t s0;
        inst_pkg::fetch_slot_t s1;
        inst_pkg::decoded_t    e0;
        inst_pkg::decoded_t    e1;
        int start;
        start = errors;
        repeat (2) begin
            make_slot(I_SUB, 2'b00, except_pkg::EXC_NONE, s0, e0);
            make_slot(I_BEQ, 2'b00, except_pkg::EXC_NONE, s1, e1);
            send_bundle(s0, s1, "flush");
        end
        wait_valid(2'b11, "flush");
        fetch_bundle[0] = s0;  // same cycle enqueue loses to flush
        fetch_bundle[1] = s1;
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        fetch_bundle = '0;
        check_bits("flush", 2'b00, dispatch_valid);
        check_bits("flush", 2'b01, {1'b0, get_data_req});
        report_test("flush", start);
    endtask

    initial begin
        #200_000;
        abort("simulation ran past its time limit");
    end

    initial begin
        rst          = 1'b1;
        flush        = 1'b0;
        fetch_bundle = '0;
        invalid_en   = 2'b00;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_alu();
        test_mem_branch();
        test_csr();
        test_exceptions();
        test_queue();
        test_flush();
        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
